// File: design/fifo_mem_pkg.sv
package fifo_mem_pkg;

    // ------------------------------------------------------------------
    // memory geometry
    // ------------------------------------------------------------------

    // words in the memory array
    localparam int DEPTH = 8;

    // payload width
    localparam int DATA_W = 16;

    // memory address width is log2 of DEPTH
    localparam int ADDR_W = 3;

    // count fields carry one extra bit
    localparam int CNT_W = ADDR_W + 1;

    // ------------------------------------------------------------------
    // read pipeline
    // ------------------------------------------------------------------

    // cycles from read strobe to data valid
    localparam int RAM_LAT = 4;

    // one slot per word in flight, plus the head
    localparam int PRE_NUM = RAM_LAT + 1;

endpackage

// File: design/fifo_flag_pkg.sv
package fifo_flag_pkg;

    // ------------------------------------------------------------------
    // occupancy and level flags
    // ------------------------------------------------------------------

    // memory words plus prefetch slots
    localparam int CAP_TOTAL = fifo_mem_pkg::DEPTH + fifo_mem_pkg::PRE_NUM;

    // threshold inputs share the count width
    localparam int TH_W = fifo_mem_pkg::CNT_W;

    // flag values out of reset
    localparam logic AFUL_RST = 1'b0;
    localparam logic AMTY_RST = 1'b1;

endpackage

// File: design/fifo_ptr_ctrl.sv
`timescale 1ns/1ps

module fifo_ptr_ctrl (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_wr,
    input  logic                              i_fetch,
    output logic                              o_mem_wr,
    output logic [fifo_mem_pkg::ADDR_W-1:0]   o_mem_waddr,
    output logic [fifo_mem_pkg::ADDR_W-1:0]   o_mem_raddr,
    output logic                              o_mem_empty,
    output logic                              o_full,
    output logic                              o_ovfl_int
);

    logic [fifo_mem_pkg::ADDR_W-1:0] wr_ptr;
    logic [fifo_mem_pkg::ADDR_W-1:0] rd_ptr;
    logic [fifo_mem_pkg::CNT_W-1:0]  mem_cnt;
    logic [fifo_mem_pkg::CNT_W-1:0]  mem_cnt_nxt;
    logic                            wr_acc;

    // write only when there is room
    assign wr_acc = i_wr & ~o_full;

    // ------------------------------------------------------------------
    // pointers
    // ------------------------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
        end else if (wr_acc) begin
            if (wr_ptr == fifo_mem_pkg::ADDR_W'(fifo_mem_pkg::DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // fetch is only raised while words are present
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
        end else if (i_fetch) begin
            if (rd_ptr == fifo_mem_pkg::ADDR_W'(fifo_mem_pkg::DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // word count and flags
    // ------------------------------------------------------------------

    always_comb begin
        case ({wr_acc, i_fetch})
            2'b10:   mem_cnt_nxt = mem_cnt + 1'b1;
            2'b01:   mem_cnt_nxt = mem_cnt - 1'b1;
            default: mem_cnt_nxt = mem_cnt;
        endcase
    end

    // flags follow the next count, so they land with it
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mem_cnt     <= '0;
            o_full      <= 1'b0;
            o_mem_empty <= 1'b1;
            o_ovfl_int  <= 1'b0;
        end else begin
            mem_cnt     <= mem_cnt_nxt;
            o_full      <= (mem_cnt_nxt == fifo_mem_pkg::CNT_W'(fifo_mem_pkg::DEPTH));
            o_mem_empty <= (mem_cnt_nxt == '0);
            o_ovfl_int  <= i_wr & o_full;
        end
    end

    assign o_mem_wr    = wr_acc;
    assign o_mem_waddr = wr_ptr;
    assign o_mem_raddr = rd_ptr;

endmodule

// File: design/fifo_ram_pipe.sv
`timescale 1ns/1ps

module fifo_ram_pipe (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_wr,
    input  logic [fifo_mem_pkg::ADDR_W-1:0]   i_waddr,
    input  logic [fifo_mem_pkg::DATA_W-1:0]   i_wdata,
    input  logic                              i_rd,
    input  logic [fifo_mem_pkg::ADDR_W-1:0]   i_raddr,
    output logic [fifo_mem_pkg::DATA_W-1:0]   o_rdata,
    output logic                              o_rval
);

    logic [fifo_mem_pkg::DATA_W-1:0] mem       [fifo_mem_pkg::DEPTH];
    logic [fifo_mem_pkg::DATA_W-1:0] data_line [fifo_mem_pkg::RAM_LAT];
    logic [fifo_mem_pkg::RAM_LAT-1:0] val_line;

    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // ------------------------------------------------------------------
    // read pipeline of RAM_LAT stages
    // ------------------------------------------------------------------

    always_ff @(posedge i_clk) begin
        data_line[0] <= mem[i_raddr];
        for (int k = 1; k < fifo_mem_pkg::RAM_LAT; k++) begin
            data_line[k] <= data_line[k-1];
        end
    end

    // valid runs beside the data
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            val_line <= '0;
        end else begin
            val_line <= {val_line[fifo_mem_pkg::RAM_LAT-2:0], i_rd};
        end
    end

    assign o_rdata = data_line[fifo_mem_pkg::RAM_LAT-1];
    assign o_rval  = val_line[fifo_mem_pkg::RAM_LAT-1];

endmodule

// File: design/fifo_prefetch.sv
`timescale 1ns/1ps

module fifo_prefetch (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_mem_empty,
    input  logic [fifo_mem_pkg::DATA_W-1:0]   i_rdata,
    input  logic                              i_rval,
    input  logic                              i_rd,
    output logic                              o_fetch,
    output logic                              o_pop,
    output logic [fifo_mem_pkg::DATA_W-1:0]   o_dout,
    output logic                              o_empty,
    output logic                              o_unfl_int
);

    logic [fifo_mem_pkg::DATA_W-1:0]  slot_data [fifo_mem_pkg::PRE_NUM];
    logic [fifo_mem_pkg::PRE_NUM-1:0] slot_val;
    logic [fifo_mem_pkg::PRE_NUM-1:0] fill_ring;
    logic [fifo_mem_pkg::PRE_NUM-1:0] pop_ring;
    logic [fifo_mem_pkg::PRE_NUM-1:0] fill_dly [fifo_mem_pkg::RAM_LAT];
    logic [fifo_mem_pkg::PRE_NUM-1:0] land;

    // ------------------------------------------------------------------
    // fetch and pop
    // ------------------------------------------------------------------

    assign o_empty = ~|(slot_val & pop_ring);
    assign o_pop   = i_rd & ~o_empty;

    // refill the popped slot, or fill a free one
    assign o_fetch = ~i_mem_empty & (o_pop | ~|(fill_ring & slot_val));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fill_ring <= fifo_mem_pkg::PRE_NUM'(1);
            pop_ring  <= fifo_mem_pkg::PRE_NUM'(1);
        end else begin
            if (o_fetch) begin
                fill_ring <= {fill_ring[fifo_mem_pkg::PRE_NUM-2:0],
                              fill_ring[fifo_mem_pkg::PRE_NUM-1]};
            end
            if (o_pop) begin
                pop_ring <= {pop_ring[fifo_mem_pkg::PRE_NUM-2:0],
                             pop_ring[fifo_mem_pkg::PRE_NUM-1]};
            end
        end
    end

    // fill slot travels with the read and lands with i_rval
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int k = 0; k < fifo_mem_pkg::RAM_LAT; k++) begin
                fill_dly[k] <= '0;
            end
        end else begin
            fill_dly[0] <= fill_ring;
            for (int k = 1; k < fifo_mem_pkg::RAM_LAT; k++) begin
                fill_dly[k] <= fill_dly[k-1];
            end
        end
    end

    assign land = fill_dly[fifo_mem_pkg::RAM_LAT-1] & {fifo_mem_pkg::PRE_NUM{i_rval}};

    // ------------------------------------------------------------------
    // slots
    // ------------------------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            slot_val <= '0;
        end else begin
            for (int i = 0; i < fifo_mem_pkg::PRE_NUM; i++) begin
                if (land[i]) begin
                    slot_val[i] <= 1'b1;
                end else if (o_pop && pop_ring[i]) begin
                    slot_val[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < fifo_mem_pkg::PRE_NUM; i++) begin
            if (land[i]) begin
                slot_data[i] <= i_rdata;
            end
        end
    end

    // head word through a one-hot mux
    always_comb begin
        o_dout = '0;
        for (int i = 0; i < fifo_mem_pkg::PRE_NUM; i++) begin
            o_dout = o_dout | (slot_data[i] & {fifo_mem_pkg::DATA_W{pop_ring[i]}});
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_unfl_int <= 1'b0;
        end else begin
            o_unfl_int <= i_rd & o_empty;
        end
    end

endmodule

// File: design/fifo_occupancy.sv
`timescale 1ns/1ps

module fifo_occupancy (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_wr,
    input  logic                               i_pop,
    input  logic [fifo_flag_pkg::TH_W-1:0]     i_aful_th,
    input  logic [fifo_flag_pkg::TH_W-1:0]     i_amty_th,
    output logic [fifo_mem_pkg::CNT_W-1:0]     o_used_cnt,
    output logic                               o_aful,
    output logic                               o_amty
);

    logic [fifo_mem_pkg::CNT_W-1:0] cnt_nxt;
    logic [fifo_flag_pkg::TH_W-1:0] aful_lvl;

    // ------------------------------------------------------------------
    // total count over memory and prefetch
    // ------------------------------------------------------------------

    always_comb begin
        case ({i_wr, i_pop})
            2'b10:   cnt_nxt = o_used_cnt + 1'b1;
            2'b01:   cnt_nxt = o_used_cnt - 1'b1;
            default: cnt_nxt = o_used_cnt;
        endcase
    end

    // almost-full level counted down from capacity
    assign aful_lvl = fifo_flag_pkg::TH_W'(fifo_flag_pkg::CAP_TOTAL) - i_aful_th;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_used_cnt <= '0;
            o_aful     <= fifo_flag_pkg::AFUL_RST;
            o_amty     <= fifo_flag_pkg::AMTY_RST;
        end else begin
            o_used_cnt <= cnt_nxt;
            o_aful     <= (cnt_nxt >= aful_lvl);
            o_amty     <= (cnt_nxt <= i_amty_th);
        end
    end

endmodule

// File: design/fifo_top.sv
`timescale 1ns/1ps

module fifo_top (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_wr,
    input  logic [fifo_mem_pkg::DATA_W-1:0]    i_din,
    input  logic                               i_rd,
    input  logic [fifo_flag_pkg::TH_W-1:0]     i_aful_th,
    input  logic [fifo_flag_pkg::TH_W-1:0]     i_amty_th,
    output logic [fifo_mem_pkg::DATA_W-1:0]    o_dout,
    output logic                               o_full,
    output logic                               o_empty,
    output logic                               o_aful,
    output logic                               o_amty,
    output logic                               o_ovfl_int,
    output logic                               o_unfl_int,
    output logic [fifo_mem_pkg::CNT_W-1:0]     o_used_cnt
);

    logic                            mem_wr;
    logic [fifo_mem_pkg::ADDR_W-1:0] mem_waddr;
    logic [fifo_mem_pkg::ADDR_W-1:0] mem_raddr;
    logic                            mem_empty;
    logic                            fetch;
    logic                            pop;
    logic [fifo_mem_pkg::DATA_W-1:0] rd_data;
    logic                            rd_val;

    fifo_ptr_ctrl ptr_ctrl_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr        (i_wr),
        .i_fetch     (fetch),
        .o_mem_wr    (mem_wr),
        .o_mem_waddr (mem_waddr),
        .o_mem_raddr (mem_raddr),
        .o_mem_empty (mem_empty),
        .o_full      (o_full),
        .o_ovfl_int  (o_ovfl_int)
    );

    fifo_ram_pipe ram_pipe_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_wr    (mem_wr),
        .i_waddr (mem_waddr),
        .i_wdata (i_din),
        .i_rd    (fetch),
        .i_raddr (mem_raddr),
        .o_rdata (rd_data),
        .o_rval  (rd_val)
    );

    // FWFT head and read side
    fifo_prefetch prefetch_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_mem_empty (mem_empty),
        .i_rdata     (rd_data),
        .i_rval      (rd_val),
        .i_rd        (i_rd),
        .o_fetch     (fetch),
        .o_pop       (pop),
        .o_dout      (o_dout),
        .o_empty     (o_empty),
        .o_unfl_int  (o_unfl_int)
    );

    fifo_occupancy occupancy_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr       (mem_wr),
        .i_pop      (pop),
        .i_aful_th  (i_aful_th),
        .i_amty_th  (i_amty_th),
        .o_used_cnt (o_used_cnt),
        .o_aful     (o_aful),
        .o_amty     (o_amty)
    );

endmodule

// File: verification/fifo_chk.sv
`timescale 1ns/1ps

module fifo_chk (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_wr,
    input  logic                              i_rd,
    input  logic                              i_full,
    input  logic                              i_empty,
    input  logic                              i_ovfl,
    input  logic                              i_unfl,
    input  logic [fifo_mem_pkg::CNT_W-1:0]    i_used_cnt
);

    // pulses only follow a rejected request
    ovfl_cause_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ovfl |-> $past(i_wr && i_full))
        else $error("overflow pulse without a write while full");

    unfl_cause_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_unfl |-> $past(i_rd && i_empty))
        else $error("underflow pulse without a read while empty");

    cnt_range_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_used_cnt <= fifo_mem_pkg::CNT_W'(fifo_flag_pkg::CAP_TOTAL))
        else $error("used count above total capacity");

    // memory full means at least DEPTH words held
    full_cnt_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_full |-> i_used_cnt >= fifo_mem_pkg::CNT_W'(fifo_mem_pkg::DEPTH))
        else $error("full flag with used count below depth");

endmodule

bind fifo_top fifo_chk chk_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr       (i_wr),
    .i_rd       (i_rd),
    .i_full     (o_full),
    .i_empty    (o_empty),
    .i_ovfl     (o_ovfl_int),
    .i_unfl     (o_unfl_int),
    .i_used_cnt (o_used_cnt)
);

// File: verification/fifo_tb.sv
`timescale 1ns/1ps

module fifo_tb;

    localparam int SEED      = 93;
    localparam int FILL_CYC  = 200;
    localparam int DRAIN_CYC = 200;
    localparam int BAL_CYC   = 300;
    localparam int STIM_CYC  = FILL_CYC + DRAIN_CYC + 2 * BAL_CYC;

    // reset, settle and final check cycles, plus slack
    localparam int CYCLE_LIMIT = STIM_CYC + 3 + 50;

    localparam int KIND_BAL   = 0;
    localparam int KIND_FILL  = 1;
    localparam int KIND_DRAIN = 2;

    logic                              i_clk;
    logic                              i_rst_n;
    logic                              i_wr;
    logic [fifo_mem_pkg::DATA_W-1:0]   i_din;
    logic                              i_rd;
    logic [fifo_flag_pkg::TH_W-1:0]    i_aful_th;
    logic [fifo_flag_pkg::TH_W-1:0]    i_amty_th;
    logic [fifo_mem_pkg::DATA_W-1:0]   o_dout;
    logic                              o_full;
    logic                              o_empty;
    logic                              o_aful;
    logic                              o_amty;
    logic                              o_ovfl_int;
    logic                              o_unfl_int;
    logic [fifo_mem_pkg::CNT_W-1:0]    o_used_cnt;

    // reference model
    logic [fifo_mem_pkg::DATA_W-1:0] model_q [$];
    logic [31:0] seed;
    logic        exp_ovfl;
    logic        exp_unfl;
    int          cur_kind;
    bit          seen_full;
    bit          seen_drained;

    int err_data  = 0;
    int err_cnt   = 0;
    int err_flag  = 0;
    int err_pulse = 0;
    int err_phase = 0;
    int cycle_cnt = 0;

    fifo_top dut_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr       (i_wr),
        .i_din      (i_din),
        .i_rd       (i_rd),
        .i_aful_th  (i_aful_th),
        .i_amty_th  (i_amty_th),
        .o_dout     (o_dout),
        .o_full     (o_full),
        .o_empty    (o_empty),
        .o_aful     (o_aful),
        .o_amty     (o_amty),
        .o_ovfl_int (o_ovfl_int),
        .o_unfl_int (o_unfl_int),
        .o_used_cnt (o_used_cnt)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // percent roll from the upper half of the seed
    function automatic logic roll_below(input logic [31:0] s, input int pct);
        return (int'(s[31:16]) % 100) < pct;
    endfunction

    // ------------------------------------------------------------------
    // output checks at the falling edge
    // ------------------------------------------------------------------

    task automatic check_outputs();
        logic [fifo_mem_pkg::CNT_W-1:0] exp_cnt;
        logic                           exp_aful;
        logic                           exp_amty;
        exp_cnt  = fifo_mem_pkg::CNT_W'(model_q.size());
        exp_aful = (model_q.size() >= fifo_flag_pkg::CAP_TOTAL - int'(i_aful_th));
        exp_amty = (model_q.size() <= int'(i_amty_th));
        assert (o_used_cnt == exp_cnt) else begin
            err_cnt++;
            $display("MISMATCH o_used_cnt: got %h expected %h", o_used_cnt, exp_cnt);
        end
        assert (o_aful == exp_aful) else begin
            err_flag++;
            $display("MISMATCH o_aful: got %h expected %h", o_aful, exp_aful);
        end
        assert (o_amty == exp_amty) else begin
            err_flag++;
            $display("MISMATCH o_amty: got %h expected %h", o_amty, exp_amty);
        end
        assert (o_ovfl_int == exp_ovfl) else begin
            err_pulse++;
            $display("MISMATCH o_ovfl_int: got %h expected %h", o_ovfl_int, exp_ovfl);
        end
        assert (o_unfl_int == exp_unfl) else begin
            err_pulse++;
            $display("MISMATCH o_unfl_int: got %h expected %h", o_unfl_int, exp_unfl);
        end
        if (cur_kind == KIND_FILL && o_full && model_q.size() >= fifo_mem_pkg::DEPTH) begin
            seen_full = 1'b1;
        end
        if (cur_kind == KIND_DRAIN && o_empty && o_used_cnt == '0) begin
            seen_drained = 1'b1;
        end
    endtask

    // check, drive and predict for the next rising edge
    task automatic step(input int wr_pct, input int rd_pct,
                        input int aful_th, input int amty_th);
        logic wr_acc;
        logic rd_acc;
        @(negedge i_clk);
        check_outputs();
        seed = lcg_next(seed);
        i_wr = roll_below(seed, wr_pct);
        seed = lcg_next(seed);
        i_rd = roll_below(seed, rd_pct);
        seed = lcg_next(seed);
        i_din = fifo_mem_pkg::DATA_W'(seed[31:16]);
        i_aful_th = fifo_flag_pkg::TH_W'(aful_th);
        i_amty_th = fifo_flag_pkg::TH_W'(amty_th);
        // flags are registered, so they already hold what the edge sees
        wr_acc   = i_wr & ~o_full;
        rd_acc   = i_rd & ~o_empty;
        exp_ovfl = i_wr & o_full;
        exp_unfl = i_rd & o_empty;
        if (rd_acc) begin
            assert (model_q.size() != 0) else begin
                err_data++;
                $display("pop accepted while the reference queue was empty");
            end
            if (model_q.size() != 0) begin
                assert (o_dout == model_q[0]) else begin
                    err_data++;
                    $display("MISMATCH o_dout: got %h expected %h", o_dout, model_q[0]);
                end
                void'(model_q.pop_front());
            end
        end
        if (wr_acc) begin
            model_q.push_back(i_din);
        end
    endtask

    task automatic run_phase(input int kind, input int wr_pct, input int rd_pct,
                             input int cycles, input int aful_th, input int amty_th);
        cur_kind     = kind;
        seen_full    = 1'b0;
        seen_drained = 1'b0;
        for (int n = 0; n < cycles; n++) begin
            step(wr_pct, rd_pct, aful_th, amty_th);
        end
        if (kind == KIND_FILL) begin
            assert (seen_full) else begin
                err_phase++;
                $display("fill phase ended without o_full at a count of DEPTH or more");
            end
        end
        if (kind == KIND_DRAIN) begin
            assert (seen_drained) else begin
                err_phase++;
                $display("drain phase ended without o_empty at a count of zero");
            end
        end
    endtask

    // ------------------------------------------------------------------
    // timeout and main sequence
    // ------------------------------------------------------------------

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int total;
        i_rst_n      = 1'b0;
        i_wr         = 1'b0;
        i_rd         = 1'b0;
        i_din        = '0;
        i_aful_th    = fifo_flag_pkg::TH_W'(2);
        i_amty_th    = fifo_flag_pkg::TH_W'(2);
        seed         = 32'(SEED);
        exp_ovfl     = 1'b0;
        exp_unfl     = 1'b0;
        cur_kind     = KIND_BAL;
        seen_full    = 1'b0;
        seen_drained = 1'b0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        run_phase(KIND_FILL, 90, 10, FILL_CYC, 3, 1);
        run_phase(KIND_DRAIN, 10, 90, DRAIN_CYC, 1, 4);
        run_phase(KIND_BAL, 50, 50, BAL_CYC, 4, 2);
        run_phase(KIND_BAL, 60, 45, BAL_CYC, 0, 0);

        // last driven cycle still needs its check
        @(negedge i_clk);
        check_outputs();

        total = err_data + err_cnt + err_flag + err_pulse + err_phase;
        $display("errors: data=%0d count=%0d flags=%0d pulses=%0d phases=%0d total=%0d",
                 err_data, err_cnt, err_flag, err_pulse, err_phase, total);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sources.f
design/fifo_mem_pkg.sv
design/fifo_flag_pkg.sv
design/fifo_ptr_ctrl.sv
design/fifo_ram_pipe.sv
design/fifo_prefetch.sv
design/fifo_occupancy.sv
design/fifo_top.sv
verification/fifo_chk.sv
verification/fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the FIFO testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert -j 0 --top-module fifo_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vfifo_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -qx "PASS: all tests"
if [ $? -ne 0 ]; then
    exit 1
fi
exit 0
